//--- logic/la_pkg.sv
`default_nettype none

package la_pkg;

  // probe and buffer geometry
  localparam int SAMPLE_W  = 8;
  localparam int BUF_DEPTH = 1024;
  localparam int BUF_AW    = $clog2(BUF_DEPTH);
  localparam int CHN_W     = 3;
  localparam int FREQ_W    = 4;
  localparam int DIV_W     = 16;  // holds 2**15 - 1

  // apb bus widths
  localparam int APB_AW = 13;
  localparam int APB_DW = 32;

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [BUF_AW-1:0]   buf_addr_t;
  typedef logic [CHN_W-1:0]    chn_t;
  typedef logic [FREQ_W-1:0]   freq_t;
  typedef logic [DIV_W-1:0]    div_cnt_t;
  typedef logic [APB_AW-1:0]   apb_addr_t;
  typedef logic [APB_DW-1:0]   apb_data_t;

  // register map, byte addresses
  localparam apb_addr_t REG_CTRL = 13'h000;  // bit 0 arms
  localparam apb_addr_t REG_CFG  = 13'h004;
  localparam apb_addr_t REG_PRE  = 13'h008;
  localparam apb_addr_t REG_STAT = 13'h00C;
  localparam apb_addr_t BUF_BASE = 13'h1000; // sample i at BUF_BASE + 4*i

  // codes 5..7 fall through to immediate
  typedef enum logic [2:0] {
    TRIG_RISE = 3'd0,
    TRIG_FALL = 3'd1,
    TRIG_HIGH = 3'd2,
    TRIG_LOW  = 3'd3,
    TRIG_NOW  = 3'd4
  } trig_mode_e;

  typedef enum logic [2:0] {
    CAP_IDLE,
    CAP_PRE,
    CAP_WAIT,
    CAP_POST,
    CAP_DONE
  } cap_state_e;

endpackage

`default_nettype wire

//--- logic/la_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface la_cfg_if import la_pkg::*; ();

  // written by the cpu side
  logic       arm;       // one cycle pulse
  chn_t       chn;
  trig_mode_e mode;
  freq_t      freq_sel;
  buf_addr_t  pre_num;

  // reported back by the capture fsm
  logic       finished;
  logic       busy;
  buf_addr_t  trig_index;

  modport regs (
    output arm, chn, mode, freq_sel, pre_num,
    input  finished, busy, trig_index
  );

  modport ctrl (
    input  arm, chn, mode, pre_num,
    output finished, busy, trig_index
  );

endinterface

`default_nettype wire

//--- logic/la_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module la_apb_regs import la_pkg::*; (
  input  wire logic      i_sys_clk,
  input  wire logic      i_reset,
  input  wire logic      i_psel,
  input  wire logic      i_penable,
  input  wire logic      i_pwrite,
  input  wire apb_addr_t i_paddr,
  input  wire apb_data_t i_pwdata,
  output apb_data_t      o_prdata,
  output logic           o_pready,
  output logic           o_pslverr,
  la_cfg_if.regs         cfg,
  output logic           o_rd_en,
  output buf_addr_t      o_rd_index,
  input  wire sample_t   i_rd_data
);

  logic       access;
  logic       is_ctrl;
  logic       is_cfg;
  logic       is_pre;
  logic       is_stat;
  logic       is_buf;
  logic       buf_rd;
  logic       addr_ok;
  logic       rd_pend;  // ram read issued last cycle

  chn_t       chn_q;
  trig_mode_e mode_q;
  freq_t      freq_q;
  buf_addr_t  pre_q;

  assign access  = i_psel & i_penable;
  assign is_ctrl = (i_paddr == REG_CTRL);
  assign is_cfg  = (i_paddr == REG_CFG);
  assign is_pre  = (i_paddr == REG_PRE);
  assign is_stat = (i_paddr == REG_STAT);
  assign is_buf  = (i_paddr >= BUF_BASE) && (i_paddr[1:0] == 2'b00);
  assign buf_rd  = is_buf & ~i_pwrite;

  // status and buffer window are read only
  assign addr_ok = is_ctrl | is_cfg | is_pre | ((is_stat | is_buf) & ~i_pwrite);

  // first access cycle of a buffer read goes to the ram, the second returns data
  assign o_rd_en    = access & buf_rd & ~rd_pend;
  assign o_rd_index = i_paddr[BUF_AW+1:2];

  assign o_pready  = ~o_rd_en;  // the only wait state
  assign o_pslverr = access & ~addr_ok;

  assign cfg.arm      = access & i_pwrite & is_ctrl & i_pwdata[0];
  assign cfg.chn      = chn_q;
  assign cfg.mode     = mode_q;
  assign cfg.freq_sel = freq_q;
  assign cfg.pre_num  = pre_q;

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= o_rd_en;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      chn_q  <= '0;
      mode_q <= TRIG_RISE;
      freq_q <= '0;
      pre_q  <= '0;
    end else if (access && i_pwrite) begin
      if (is_cfg) begin
        chn_q  <= i_pwdata[2:0];
        mode_q <= trig_mode_e'(i_pwdata[6:4]);
        freq_q <= i_pwdata[11:8];
      end
      if (is_pre) begin
        pre_q <= i_pwdata[9:0];
      end
    end
  end

  // read mux, unused bits stay zero
  always_comb begin
    o_prdata = '0;
    if (access && !i_pwrite) begin
      if (is_cfg) begin
        o_prdata = {20'b0, freq_q, 1'b0, mode_q, 1'b0, chn_q};
      end else if (is_pre) begin
        o_prdata = {22'b0, pre_q};
      end else if (is_stat) begin
        o_prdata = {6'b0, cfg.trig_index, 14'b0, cfg.busy, cfg.finished};
      end else if (is_buf) begin
        o_prdata = {24'b0, i_rd_data}; // valid in the second access cycle
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/la_rate_div.sv
`timescale 1ns/1ps
`default_nettype none

module la_rate_div import la_pkg::*; (
  input  wire logic  i_sys_clk,
  input  wire logic  i_reset,
  input  wire logic  i_restart,
  input  wire freq_t i_freq_sel,
  output logic       o_sample_en
);

  div_cnt_t cnt;
  div_cnt_t period_m1;

  // period is 2**freq_sel cycles
  assign period_m1 = (div_cnt_t'(1) << i_freq_sel) - div_cnt_t'(1);

  // >= keeps things sane if freq_sel shrinks mid count
  assign o_sample_en = (cnt >= period_m1);

  always_ff @(posedge i_sys_clk) begin
    if (i_reset || i_restart) begin
      cnt <= '0;
    end else if (o_sample_en) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + div_cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- logic/la_sample_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module la_sample_ctrl import la_pkg::*; (
  input  wire logic    i_sys_clk,
  input  wire logic    i_reset,
  la_cfg_if.ctrl       cfg,
  input  wire logic    i_sample_en,
  input  wire sample_t i_data,
  output logic         o_wr_en,
  output buf_addr_t    o_wr_addr,
  output sample_t      o_wr_data,
  output buf_addr_t    o_start_addr
);

  cap_state_e state;
  buf_addr_t  samp_idx;    // sample index, also the ram write address
  buf_addr_t  trig_index;
  logic       have_prev;   // at least one sample seen since arm

  // settings frozen at arm
  buf_addr_t  pre_q;
  chn_t       chn_q;
  trig_mode_e mode_q;

  logic       prev_bit;
  buf_addr_t  start_addr;
  buf_addr_t  trig_start;  // start address if the current sample triggers
  buf_addr_t  last_addr;
  logic       last_sample;
  logic       capturing;
  logic       cur_bit;
  logic       trig_hit;

  assign capturing = (state == CAP_PRE) || (state == CAP_WAIT) || (state == CAP_POST);
  assign cur_bit   = i_data[chn_q];

  always_comb begin
    case (mode_q)
      TRIG_RISE: trig_hit = have_prev & ~prev_bit & cur_bit;
      TRIG_FALL: trig_hit = have_prev & prev_bit & ~cur_bit;
      TRIG_HIGH: trig_hit = cur_bit;
      TRIG_LOW:  trig_hit = ~cur_bit;
      default:   trig_hit = 1'b1;  // immediate
    endcase
  end

  assign trig_start = samp_idx - pre_q;

  // buffer is full once the write lands just below start_addr
  assign last_addr   = (state == CAP_POST) ? buf_addr_t'(start_addr - 10'd1)
                                           : buf_addr_t'(trig_start - 10'd1);
  assign last_sample = (samp_idx == last_addr);

  // a sample coinciding with arm belongs to the old capture, dropped
  assign o_wr_en   = i_sample_en & capturing & ~cfg.arm;
  assign o_wr_addr = samp_idx;
  assign o_wr_data = i_data;

  assign o_start_addr   = start_addr;
  assign cfg.busy       = capturing;
  assign cfg.finished   = (state == CAP_DONE);
  assign cfg.trig_index = trig_index;

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      state      <= CAP_IDLE;
      samp_idx   <= '0;
      trig_index <= '0;
      have_prev  <= 1'b0;
    end else if (cfg.arm) begin
      // restart from any state
      state      <= (cfg.pre_num == '0) ? CAP_WAIT : CAP_PRE;
      samp_idx   <= '0;
      trig_index <= '0;
      have_prev  <= 1'b0;
    end else if (o_wr_en) begin
      samp_idx  <= samp_idx + 10'd1;
      have_prev <= 1'b1;
      case (state)
        CAP_PRE: begin
          if (samp_idx == buf_addr_t'(pre_q - 10'd1)) begin
            state <= CAP_WAIT;
          end
        end
        CAP_WAIT: begin
          if (trig_hit) begin
            trig_index <= samp_idx;
            // pre_num of 1023 leaves room for the trigger sample only
            state      <= last_sample ? CAP_DONE : CAP_POST;
          end
        end
        CAP_POST: begin
          if (last_sample) begin
            state <= CAP_DONE;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (cfg.arm) begin
      pre_q  <= cfg.pre_num;
      chn_q  <= cfg.chn;
      mode_q <= cfg.mode;
    end
    if (o_wr_en) begin
      prev_bit <= cur_bit;
    end
    if (o_wr_en && (state == CAP_WAIT) && trig_hit) begin
      start_addr <= trig_start;  // oldest kept sample
    end
  end

endmodule

`default_nettype wire

//--- logic/la_sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module la_sample_buffer import la_pkg::*; (
  input  wire logic      i_sys_clk,
  input  wire logic      i_wr_en,
  input  wire buf_addr_t i_wr_addr,
  input  wire sample_t   i_wr_data,
  input  wire buf_addr_t i_start_addr,
  input  wire logic      i_rd_en,
  input  wire buf_addr_t i_rd_index,
  output sample_t        o_rd_data
);

  sample_t   ram [BUF_DEPTH];
  buf_addr_t rd_addr;

  // index 0 maps to the oldest sample, 10 bit add wraps around the ring
  assign rd_addr = i_start_addr + i_rd_index;

  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) begin
      ram[i_wr_addr] <= i_wr_data;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_rd_en) begin
      o_rd_data <= ram[rd_addr];  // one cycle read latency
    end
  end

endmodule

`default_nettype wire

//--- logic/la_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module la_capture_top import la_pkg::*; (
  input  wire logic      i_sys_clk,
  input  wire logic      i_reset,
  // apb slave
  input  wire logic      i_psel,
  input  wire logic      i_penable,
  input  wire logic      i_pwrite,
  input  wire apb_addr_t i_paddr,
  input  wire apb_data_t i_pwdata,
  output apb_data_t      o_prdata,
  output logic           o_pready,
  output logic           o_pslverr,
  // probe bus
  input  wire sample_t   i_data
);

  la_cfg_if cfg ();

  logic      sample_en;
  logic      wr_en;
  buf_addr_t wr_addr;
  sample_t   wr_data;
  buf_addr_t start_addr;
  logic      rd_en;
  buf_addr_t rd_index;
  sample_t   rd_data;

  la_apb_regs u_apb_regs (
    .i_sys_clk  ( i_sys_clk ),
    .i_reset    ( i_reset   ),
    .i_psel     ( i_psel    ),
    .i_penable  ( i_penable ),
    .i_pwrite   ( i_pwrite  ),
    .i_paddr    ( i_paddr   ),
    .i_pwdata   ( i_pwdata  ),
    .o_prdata   ( o_prdata  ),
    .o_pready   ( o_pready  ),
    .o_pslverr  ( o_pslverr ),
    .cfg        ( cfg.regs  ),
    .o_rd_en    ( rd_en     ),
    .o_rd_index ( rd_index  ),
    .i_rd_data  ( rd_data   )
  );

  // divider restarts with every arm
  la_rate_div u_rate_div (
    .i_sys_clk   ( i_sys_clk    ),
    .i_reset     ( i_reset      ),
    .i_restart   ( cfg.arm      ),
    .i_freq_sel  ( cfg.freq_sel ),
    .o_sample_en ( sample_en    )
  );

  la_sample_ctrl u_sample_ctrl (
    .i_sys_clk    ( i_sys_clk  ),
    .i_reset      ( i_reset    ),
    .cfg          ( cfg.ctrl   ),
    .i_sample_en  ( sample_en  ),
    .i_data       ( i_data     ),
    .o_wr_en      ( wr_en      ),
    .o_wr_addr    ( wr_addr    ),
    .o_wr_data    ( wr_data    ),
    .o_start_addr ( start_addr )
  );

  la_sample_buffer u_sample_buffer (
    .i_sys_clk    ( i_sys_clk  ),
    .i_wr_en      ( wr_en      ),
    .i_wr_addr    ( wr_addr    ),
    .i_wr_data    ( wr_data    ),
    .i_start_addr ( start_addr ),
    .i_rd_en      ( rd_en      ),
    .i_rd_index   ( rd_index   ),
    .o_rd_data    ( rd_data    )
  );

endmodule

`default_nettype wire

//--- testbench/la_capture_sva.sv
`timescale 1ns/1ps
`default_nettype none

module la_capture_sva import la_pkg::*; (
  input wire logic      i_sys_clk,
  input wire logic      i_reset,
  input wire logic      i_psel,
  input wire logic      i_penable,
  input wire apb_addr_t i_paddr,
  input wire logic      i_pready,
  input wire logic      i_wr_en,
  input wire logic      i_busy,
  input wire logic      i_finished
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // everything below the buffer window answers in the first access cycle
  a_reg_ready: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    (i_psel && i_penable && (i_paddr < BUF_BASE)) |-> i_pready)
    else begin
      $error("register access not ready in first access cycle");
      fail_cnt++;
    end

  a_idle_no_write: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    !i_busy |-> !i_wr_en)
    else begin
      $error("ram write while capture idle");
      fail_cnt++;
    end

  a_busy_or_done: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    !(i_busy && i_finished))
    else begin
      $error("busy and finished high together");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- testbench/tb_la_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la_capture import la_pkg::*; ();

  localparam int MAX_TESTS  = 16;
  localparam int STREAM_LEN = 2048;

  logic      i_sys_clk;
  logic      i_reset;
  logic      i_psel;
  logic      i_penable;
  logic      i_pwrite;
  apb_addr_t i_paddr;
  apb_data_t i_pwdata;
  apb_data_t o_prdata;
  logic      o_pready;
  logic      o_pslverr;
  sample_t   i_data;

  int unsigned lcg_state;
  int          cycles;
  int          cycle_limit;
  int          num_tests;
  int          t_freq [MAX_TESTS];
  int          t_chn  [MAX_TESTS];
  int          t_mode [MAX_TESTS];
  int          t_pre  [MAX_TESTS];
  int          t_trig [MAX_TESTS];
  int          t_exp  [MAX_TESTS];
  sample_t     stream [STREAM_LEN];  // reference copy of the probe stream
  logic        stream_on;

  la_capture_top u_dut (.*);

  bind la_capture_top la_capture_sva u_sva (
    .i_pready   ( o_pready     ),
    .i_wr_en    ( wr_en        ),
    .i_busy     ( cfg.busy     ),
    .i_finished ( cfg.finished ),
    .*
  );

  always #2 i_sys_clk = ~i_sys_clk;

  always @(posedge i_sys_clk) begin
    cycles++;
    if (u_dut.u_sva.fail_cnt != 0) begin
      $display("error: %0t a bound assertion on the dut failed", $time);
      abort_run();
    end else if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("error: timeout after %0d cycles, capture or readout never completed", cycles);
      abort_run();
    end
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_index(input string name, input buf_addr_t got, input buf_addr_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // one apb transfer, buffer reads take exactly one wait state
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          input logic exp_err, output apb_data_t rdata);
    logic buf_read;
    buf_read  = !wr && (addr >= BUF_BASE);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(posedge i_sys_clk);
    #1 i_penable = 1'b1;
    @(negedge i_sys_clk);
    if (buf_read) begin
      check_flag("o_pready", o_pready, 1'b0);  // the wait state
      @(negedge i_sys_clk);
    end
    check_flag("o_pready", o_pready, 1'b1);
    rdata = o_prdata;
    check_flag("o_pslverr", o_pslverr, exp_err);
    @(posedge i_sys_clk);
    #1 i_psel = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic build_stream(input int n);
    logic act;
    act = (t_mode[n] == TRIG_FALL || t_mode[n] == TRIG_LOW) ? 1'b0 : 1'b1;
    for (int k = 0; k < STREAM_LEN; k++) begin
      lcg_state = lcg_next(lcg_state);
      stream[k] = lcg_state[23:16];
      stream[k][t_chn[n]] = (k >= t_trig[n]) ? act : ~act;  // inactive before trig_at
    end
  endtask

  // starts with the apb setup cycle of the arm write
  task automatic drive_stream(input int f);
    int k;
    k = 1;
    i_data = stream[0];
    @(posedge i_sys_clk);  // arm cycle begins
    repeat ((1 << f) + 1) @(posedge i_sys_clk);
    while (stream_on && k < STREAM_LEN) begin
      #1 i_data = stream[k];  // one cycle after enable k-1
      k++;
      repeat (1 << f) @(posedge i_sys_clk);
    end
  endtask

  task automatic run_test(input int n);
    apb_data_t word;
    apb_data_t cfg_word;
    int        f;
    int        base;
    f = t_freq[n];
    cfg_word = apb_data_t'((f << 8) | (t_mode[n] << 4) | t_chn[n]);
    apb_xfer(1'b1, REG_CFG, cfg_word, 1'b0, word);
    apb_xfer(1'b1, REG_PRE, apb_data_t'(t_pre[n]), 1'b0, word);
    apb_xfer(1'b0, REG_CFG, '0, 1'b0, word);
    check_word("o_prdata cfg", word, cfg_word);
    apb_xfer(1'b0, REG_PRE, '0, 1'b0, word);
    check_word("o_prdata pre", word, apb_data_t'(t_pre[n]));
    build_stream(n);
    stream_on = 1'b1;
    fork
      drive_stream(f);
    join_none
    apb_xfer(1'b1, REG_CTRL, 32'h1, 1'b0, word);
    apb_xfer(1'b0, REG_STAT, '0, 1'b0, word);
    check_flag("finished after arm", word[0], 1'b0);
    check_flag("busy after arm", word[1], 1'b1);
    while (!word[0]) begin
      apb_xfer(1'b0, REG_STAT, '0, 1'b0, word);
    end
    stream_on = 1'b0;
    check_index("trig_index", word[25:16], buf_addr_t'(t_exp[n]));
    check_word("o_prdata stat", word, {6'b0, buf_addr_t'(t_exp[n]), 14'b0, 2'b01});
    base = t_exp[n] - t_pre[n];  // oldest kept sample
    for (int i = 0; i < BUF_DEPTH; i++) begin
      apb_xfer(1'b0, BUF_BASE + apb_addr_t'(4 * i), '0, 1'b0, word);
      check_sample($sformatf("buffer[%0d]", i), word[7:0], stream[base + i]);
      check_word("o_prdata buffer upper bits", {word[31:8], 8'h00}, 32'h0);
    end
  endtask

  initial begin
    int        fd;
    int        c;
    string     line;
    apb_data_t word;
    i_sys_clk   = 1'b0;
    i_reset     = 1'b1;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_data      = '0;
    lcg_state   = 72776;
    cycles      = 0;
    cycle_limit = 0;
    num_tests   = 0;
    stream_on   = 1'b0;
    fd = $fopen("testbench/la_testdata.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open testbench/la_testdata.txt");
      abort_run();
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
      c = $fgets(line, fd);
      if (c > 0 && line[0] != "#") begin
        if ($sscanf(line, "%d %d %d %d %d %d", t_freq[num_tests], t_chn[num_tests],
                    t_mode[num_tests], t_pre[num_tests], t_trig[num_tests],
                    t_exp[num_tests]) == 6) begin
          num_tests++;
        end
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      $display("error: no test cases found in the testdata file");
      abort_run();
    end
    for (int n = 0; n < num_tests; n++) begin
      cycle_limit += ((BUF_DEPTH + t_trig[n] + 2) << t_freq[n]) + 4 * BUF_DEPTH;
    end
    cycle_limit += 1000;  // reset and register checks
    repeat (3) @(posedge i_sys_clk);
    #1 i_reset = 1'b0;
    // unused bits read back as zero
    apb_xfer(1'b0, REG_STAT, '0, 1'b0, word);
    check_word("o_prdata stat reset", word, 32'h0);
    apb_xfer(1'b1, REG_CFG, 32'hFFFF_FFFF, 1'b0, word);
    apb_xfer(1'b1, REG_PRE, 32'hFFFF_FFFF, 1'b0, word);
    apb_xfer(1'b0, REG_CFG, '0, 1'b0, word);
    check_word("o_prdata cfg", word, 32'h0000_0F77);
    apb_xfer(1'b0, REG_PRE, '0, 1'b0, word);
    check_word("o_prdata pre", word, 32'h0000_03FF);
    apb_xfer(1'b1, REG_STAT, 32'h1, 1'b1, word);  // read only
    apb_xfer(1'b0, 13'h010, '0, 1'b1, word);
    apb_xfer(1'b1, BUF_BASE, 32'h5A, 1'b1, word);
    for (int n = 0; n < num_tests; n++) begin
      run_test(n);
    end
    if (u_dut.u_sva.fail_cnt != 0) begin
      $display("error: %0t a bound assertion on the dut failed", $time);
      abort_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
logic/la_pkg.sv
logic/la_cfg_if.sv
logic/la_apb_regs.sv
logic/la_rate_div.sv
logic/la_sample_ctrl.sv
logic/la_sample_buffer.sv
logic/la_capture_top.sv
testbench/la_capture_sva.sv
testbench/tb_la_capture.sv

//--- Bender.yml
package:
  name: la_capture

sources:
  - logic/la_pkg.sv
  - logic/la_cfg_if.sv
  - logic/la_apb_regs.sv
  - logic/la_rate_div.sv
  - logic/la_sample_ctrl.sv
  - logic/la_sample_buffer.sv
  - logic/la_capture_top.sv
  - target: test
    files:
      - testbench/la_capture_sva.sv
      - testbench/tb_la_capture.sv

//--- testbench/la_testdata.txt
# freq_sel chn mode pre_num trig_at exp_trig_index
# mode 0 rise, 1 fall, 2 high, 3 low, 4 immediate
0 0 0 0 5 5
1 3 1 100 300 300
2 5 2 512 600 600
0 7 3 1023 1023 1023
1 2 4 200 0 200
0 1 0 10 10 10
